//--- Bender.yml
package:
  name: ita_ctrl

sources:
  - files:
      - rtl/ita_pkg.sv
      - rtl/ita_step_decode.sv
      - rtl/ita_tile_sequencer.sv
      - rtl/ita_edge_pad.sv
      - rtl/ita_ctrl_top.sv
  - target: test
    files:
      - testbench/ita_ctrl_asserts.sv
      - testbench/tb_ita_ctrl.sv

//--- ita_ctrl_top.f
rtl/ita_pkg.sv
rtl/ita_step_decode.sv
rtl/ita_tile_sequencer.sv
rtl/ita_edge_pad.sv
rtl/ita_ctrl_top.sv
testbench/ita_ctrl_asserts.sv
testbench/tb_ita_ctrl.sv

//--- rtl/ita_ctrl_top.sv
/*
  Linear and feedforward tile controller. Padded lanes follow the accepted
  beat by one cycle. Dimensions must be held stable while busy_o is high.
*/

module ita_ctrl_top
  import ita_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  layer_e                 layer_i,
  input  dim_t                   seq_length_i,
  input  dim_t                   embed_size_i,
  input  dim_t                   proj_space_i,
  input  dim_t                   ff_size_i,
  input  logic                   inp_valid_i,
  input  logic                   weight_valid_i,
  input  logic                   bias_valid_i,
  output logic                   inp_ready_o,
  output logic                   weight_ready_o,
  output logic                   bias_ready_o,
  input  logic                   oup_valid_i,
  input  logic                   oup_ready_i,
  input  bias_lane_t [Lanes-1:0] bias_i,
  input  logic                   requant_add_i,
  output step_e                  step_o,
  output logic                   busy_o,
  output logic                   calc_en_o,
  output logic                   first_inner_tile_o,
  output logic                   last_inner_tile_o,
  output counter_t               tile_x_o,
  output counter_t               tile_y_o,
  output counter_t               inner_tile_o,
  output bias_lane_t [Lanes-1:0] bias_pad_o,
  output logic [Lanes-1:0]       requant_add_o,
  output logic                   pad_valid_o
);

  counter_t inner_lim, x_lim, y_lim, beat;
  dim_t     first_dim, second_dim;
  logic     step_done;

  ita_step_decode u_decode (
    .clk_i, .rst_ni, .start_i, .layer_i,
    .seq_length_i, .embed_size_i, .proj_space_i, .ff_size_i,
    .step_done_i  (step_done),
    .step_o,
    .inner_lim_o  (inner_lim),
    .x_lim_o      (x_lim),
    .y_lim_o      (y_lim),
    .first_dim_o  (first_dim),
    .second_dim_o (second_dim)
  );

  ita_tile_sequencer u_sequencer (
    .clk_i, .rst_ni,
    .step_i      (step_o),
    .inner_lim_i (inner_lim),
    .x_lim_i     (x_lim),
    .y_lim_i     (y_lim),
    .inp_valid_i, .weight_valid_i, .bias_valid_i, .oup_valid_i, .oup_ready_i,
    .inp_ready_o, .weight_ready_o, .bias_ready_o, .calc_en_o,
    .first_inner_tile_o, .last_inner_tile_o,
    .beat_o      (beat),
    .inner_tile_o, .tile_x_o, .tile_y_o,
    .step_done_o (step_done)
  );

  ita_edge_pad #(.lane_t(bias_lane_t)) u_bias_pad (
    .clk_i, .rst_ni,
    .accept_i (calc_en_o), .beat_i (beat), .tile_x_i (tile_x_o), .tile_y_i (tile_y_o),
    .first_dim_i (first_dim), .second_dim_i (second_dim),
    .lanes_i  (bias_i),
    .lanes_o  (bias_pad_o),
    .valid_o  (pad_valid_o)
  );

  // one requant flag per beat, spread over all lanes
  ita_edge_pad #(.lane_t(logic)) u_requant_pad (
    .clk_i, .rst_ni,
    .accept_i (calc_en_o), .beat_i (beat), .tile_x_i (tile_x_o), .tile_y_i (tile_y_o),
    .first_dim_i (first_dim), .second_dim_i (second_dim),
    .lanes_i  ({Lanes{requant_add_i}}),
    .lanes_o  (requant_add_o),
    .valid_o  ()  // same timing as u_bias_pad
  );

  assign busy_o = (step_o != Idle);

endmodule

//--- rtl/ita_edge_pad.sv
/*
  Zeroes lanes of an accepted beat that lie past the matrix edge.
  lane_t must be a packed type. lanes_o holds its value between beats.
*/

module ita_edge_pad
  import ita_pkg::*;
#(
  parameter type lane_t = logic
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              accept_i,
  input  counter_t          beat_i,
  input  counter_t          tile_x_i,
  input  counter_t          tile_y_i,
  input  dim_t              first_dim_i,
  input  dim_t              second_dim_i,
  input  lane_t [Lanes-1:0] lanes_i,
  output lane_t [Lanes-1:0] lanes_o,
  output logic              valid_o
);

  logic [15:0]       row, col_base;
  lane_t [Lanes-1:0] lanes_d, lanes_q;
  logic              valid_q;

  // low beat bits pick the row, high bits the column chunk
  assign row      = 16'(tile_y_i * TileRows + beat_i % TileRows);
  assign col_base = 16'(tile_x_i * TileRows + (beat_i / TileRows) * Lanes);

  always_comb begin
    lanes_d = lanes_i;
    for (int i = 0; i < Lanes; i++) begin
      if (row >= 16'(first_dim_i) || col_base + 16'(i) >= 16'(second_dim_i)) begin
        lanes_d[i] = '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) lanes_q <= lanes_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept_i;
    end
  end

  assign lanes_o = lanes_q;
  assign valid_o = valid_q;

endmodule

//--- rtl/ita_pkg.sv
/*
  Shared tile geometry and types of the tile-sequencing controller.
  Dimensions are 8 bit and must be at least 1. Tile counts saturate at 32.
*/

package ita_pkg;

  // tile geometry
  localparam int unsigned TileRows     = 8;  // rows and columns of one tile
  localparam int unsigned Lanes        = 4;  // elements per beat
  localparam int unsigned BeatsPerTile = TileRows * TileRows / Lanes;

  // output beats allowed in flight downstream
  localparam int unsigned FifoDepth = 4;

  localparam int unsigned BiasLaneW = 24;

  typedef logic [7:0] dim_t;
  typedef logic [7:0] counter_t;

  typedef logic signed [BiasLaneW-1:0] bias_lane_t;

  typedef enum logic [1:0] {
    Linear      = 2'd0,
    Feedforward = 2'd1
  } layer_e;

  typedef enum logic [1:0] {
    Idle   = 2'd0,
    MatMul = 2'd1,
    F1     = 2'd2,
    F2     = 2'd3
  } step_e;

  // ceil(d / TileRows)
  function automatic counter_t tile_count(dim_t d);
    counter_t whole;
    logic     part;
    whole = counter_t'(d / TileRows);
    part  = (d % TileRows) != 0;
    return whole + counter_t'(part);
  endfunction

endpackage

//--- rtl/ita_step_decode.sv
/*
  Step FSM of the controller. start_i is ignored unless the FSM is idle.
  Dimensions must stay stable while a step runs.
*/

module ita_step_decode
  import ita_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  layer_e   layer_i,
  input  dim_t     seq_length_i,
  input  dim_t     embed_size_i,
  input  dim_t     proj_space_i,
  input  dim_t     ff_size_i,
  input  logic     step_done_i,
  output step_e    step_o,
  output counter_t inner_lim_o,
  output counter_t x_lim_o,
  output counter_t y_lim_o,
  output dim_t     first_dim_o,
  output dim_t     second_dim_o
);

  step_e step_d, step_q;

  always_comb begin
    step_d = step_q;
    unique case (step_q)
      Idle: begin
        if (start_i) begin
          step_d = (layer_i == Feedforward) ? F1 : MatMul;
        end
      end
      MatMul: if (step_done_i) step_d = Idle;
      F1:     if (step_done_i) step_d = F2;
      F2:     if (step_done_i) step_d = Idle;
      default: step_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q <= Idle;
    end else begin
      step_q <= step_d;
    end
  end

  // loop limits and padding edge of the running step
  always_comb begin
    inner_lim_o  = '0;
    x_lim_o      = '0;
    second_dim_o = '0;
    unique case (step_q)
      MatMul: begin
        inner_lim_o  = tile_count(embed_size_i);
        x_lim_o      = tile_count(proj_space_i);
        second_dim_o = proj_space_i;
      end
      F1: begin
        inner_lim_o  = tile_count(embed_size_i);
        x_lim_o      = tile_count(ff_size_i);
        second_dim_o = ff_size_i;
      end
      F2: begin
        inner_lim_o  = tile_count(ff_size_i);
        x_lim_o      = tile_count(embed_size_i);
        second_dim_o = embed_size_i;
      end
      default: ;  // idle, nothing runs
    endcase
  end

  assign y_lim_o     = tile_count(seq_length_i);  // rows are always the sequence
  assign first_dim_o = seq_length_i;
  assign step_o      = step_q;

endmodule

//--- rtl/ita_tile_sequencer.sv
/*
  Beat gating and tile counters. The readies keep the reference's cross-wired
  valid/ready strobes. The downstream FIFO must never be popped while empty.
*/

module ita_tile_sequencer
  import ita_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  step_e    step_i,
  input  counter_t inner_lim_i,
  input  counter_t x_lim_i,
  input  counter_t y_lim_i,
  input  logic     inp_valid_i,
  input  logic     weight_valid_i,
  input  logic     bias_valid_i,
  input  logic     oup_valid_i,
  input  logic     oup_ready_i,
  output logic     inp_ready_o,
  output logic     weight_ready_o,
  output logic     bias_ready_o,
  output logic     calc_en_o,
  output logic     first_inner_tile_o,
  output logic     last_inner_tile_o,
  output counter_t beat_o,
  output counter_t inner_tile_o,
  output counter_t tile_x_o,
  output counter_t tile_y_o,
  output logic     step_done_o
);

  counter_t beat_d, beat_q;
  counter_t inner_d, inner_q;
  counter_t tile_x_d, tile_x_q;
  counter_t tile_y_d, tile_y_q;
  counter_t occ_d, occ_q;  // output beats in flight

  logic beat_open, accept;
  logic push, pop;
  logic tile_end, inner_end, row_end, step_end;

  assign beat_open = (step_i != Idle) && (occ_q < counter_t'(FifoDepth));

  assign inp_ready_o    = beat_open & weight_valid_i;
  assign weight_ready_o = beat_open & inp_valid_i;
  assign bias_ready_o   = beat_open & weight_valid_i;

  assign accept    = beat_open & inp_valid_i & weight_valid_i & bias_valid_i;
  assign calc_en_o = accept;

  assign first_inner_tile_o = (inner_q == '0);
  assign last_inner_tile_o  = (inner_q == inner_lim_i - 1'b1);

  assign tile_end    = (beat_q == counter_t'(BeatsPerTile - 1));
  assign inner_end   = tile_end & last_inner_tile_o;
  assign row_end     = inner_end & (tile_x_q == x_lim_i - 1'b1);
  assign step_end    = row_end & (tile_y_q == y_lim_i - 1'b1);
  assign step_done_o = accept & step_end;

  always_comb begin
    beat_d   = beat_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;
    if (step_i == Idle || step_done_o) begin  // next step starts from zero
      beat_d   = '0;
      inner_d  = '0;
      tile_x_d = '0;
      tile_y_d = '0;
    end else if (accept) begin
      beat_d = beat_q + 1'b1;
      if (tile_end) begin
        beat_d  = '0;
        inner_d = inner_q + 1'b1;
        if (last_inner_tile_o) begin
          inner_d  = '0;
          tile_x_d = tile_x_q + 1'b1;
          if (row_end) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
          end
        end
      end
    end
  end

  // only the last inner tile produces an output beat
  assign push = accept & last_inner_tile_o;
  assign pop  = oup_valid_i & oup_ready_i;

  always_comb begin
    unique case ({push, pop})
      2'b10:   occ_d = occ_q + 1'b1;
      2'b01:   occ_d = occ_q - 1'b1;
      default: occ_d = occ_q;  // push and pop cancel
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q   <= '0;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
      occ_q    <= '0;
    end else begin
      beat_q   <= beat_d;
      inner_q  <= inner_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
      occ_q    <= occ_d;
    end
  end

  assign beat_o       = beat_q;
  assign inner_tile_o = inner_q;
  assign tile_x_o     = tile_x_q;
  assign tile_y_o     = tile_y_q;

endmodule

//--- testbench/ita_ctrl_asserts.sv
/*
  Concurrent checks on the tile sequencer, bound into ita_tile_sequencer.
  failures counts every failed assertion for the end-of-run summary.
*/

module ita_ctrl_asserts
  import ita_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input step_e    step_i,
  input logic     inp_valid_i,
  input logic     weight_valid_i,
  input logic     bias_valid_i,
  input logic     inp_ready_i,
  input logic     weight_ready_i,
  input logic     bias_ready_i,
  input logic     calc_en_i,
  input counter_t occ_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  accept_needs_valids: assert property (@(posedge clk_i) disable iff (!rst_ni)
    calc_en_i |-> inp_valid_i && weight_valid_i && bias_valid_i)
  else begin
    $error("beat accepted without all three valids");
    failures++;
  end

  occ_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    occ_i <= counter_t'(FifoDepth))
  else begin
    $error("output occupancy above fifo depth");
    failures++;
  end

  idle_no_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_i == Idle |-> !(inp_ready_i || weight_ready_i || bias_ready_i))
  else begin
    $error("ready raised while idle");
    failures++;
  end

endmodule

bind ita_tile_sequencer ita_ctrl_asserts u_asserts (
  .clk_i, .rst_ni, .step_i, .inp_valid_i, .weight_valid_i, .bias_valid_i,
  .inp_ready_i    (inp_ready_o),
  .weight_ready_i (weight_ready_o),
  .bias_ready_i   (bias_ready_o),
  .calc_en_i      (calc_en_o),
  .occ_i          (occ_q)
);

//--- testbench/tb_ita_ctrl.sv
/*
  Testbench of ita_ctrl_top. Inputs change on the falling edge and outputs
  are sampled a quarter period before the rising edge.
*/

module tb_ita_ctrl
  import ita_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          ClkPeriod = 40;
  localparam int unsigned Seed      = 32'h9399_bd83;
  localparam int          LongWait  = 3000;  // cycles per layer
  localparam int          FillWait  = 300;
  localparam int          StallLen  = 24;

  logic clk_i, rst_ni, start_i, requant_add_i;
  layer_e layer_i;
  dim_t seq_length_i, embed_size_i, proj_space_i, ff_size_i;
  logic inp_valid_i, weight_valid_i, bias_valid_i, oup_valid_i, oup_ready_i;
  logic inp_ready_o, weight_ready_o, bias_ready_o, calc_en_o, busy_o, pad_valid_o;
  logic first_inner_tile_o, last_inner_tile_o;
  step_e step_o;
  counter_t tile_x_o, tile_y_o, inner_tile_o;
  bias_lane_t [Lanes-1:0] bias_i, bias_pad_o, exp_bias;
  logic [Lanes-1:0] requant_add_o, exp_rq;

  int errors, tests_run, tests_failed;
  int beat_count [4];
  int pushes, occ_model, zero_rows, partial_beats;
  int trk_beat, trk_inner, trk_x, trk_y;  // own walk through the tiles
  bit pend, drain_en;
  step_e last_step;
  step_e step_seen [$];

  ita_ctrl_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic int ceil_tiles(input int d);
    return (d + TileRows - 1) / TileRows;
  endfunction

  function automatic void step_geometry(input step_e s, output int inner_n, output int x_n,
                                        output int cols);
    inner_n = 0;
    x_n     = 0;
    cols    = 0;
    case (s)
      MatMul: begin
        inner_n = ceil_tiles(embed_size_i);
        x_n     = ceil_tiles(proj_space_i);
        cols    = proj_space_i;
      end
      F1: begin
        inner_n = ceil_tiles(embed_size_i);
        x_n     = ceil_tiles(ff_size_i);
        cols    = ff_size_i;
      end
      F2: begin
        inner_n = ceil_tiles(ff_size_i);
        x_n     = ceil_tiles(embed_size_i);
        cols    = embed_size_i;
      end
      default: ;
    endcase
  endfunction

  function automatic int expected_beats(input step_e s);
    int inner_n, x_n, cols;
    step_geometry(s, inner_n, x_n, cols);
    return BeatsPerTile * inner_n * x_n * ceil_tiles(seq_length_i);
  endfunction

  // lanes of a beat that lie inside the matrix
  function automatic logic [Lanes-1:0] ref_mask(input int beat, input int tx, input int ty,
                                                input int rows, input int cols);
    logic [Lanes-1:0] m;
    int row, col;
    row = ty * TileRows + beat % TileRows;
    for (int i = 0; i < Lanes; i++) begin
      col  = tx * TileRows + (beat / TileRows) * Lanes + i;
      m[i] = (row < rows) && (col < cols);
    end
    return m;
  endfunction

  function automatic int total_errors();
    return errors + DUT.u_sequencer.u_asserts.failures;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic sample_cycle();
    int inner_n, x_n, cols;
    logic [Lanes-1:0] m;
    bit open;
    if (step_o != last_step) begin
      step_seen.push_back(step_o);
      last_step = step_o;
    end
    check_value("pad_valid_o", pad_valid_o, pend);
    if (pend) begin  // beat accepted one cycle ago
      check_value("bias_pad_o", bias_pad_o, exp_bias);
      check_value("requant_add_o", requant_add_o, exp_rq);
    end
    // cross-wired strobes, gated by the modelled fifo room
    open = (step_o != Idle) && (occ_model < FifoDepth);
    check_value("ready", {inp_ready_o, weight_ready_o, bias_ready_o},
                open ? {weight_valid_i, inp_valid_i, weight_valid_i} : 3'b000);
    check_value("calc_en_o", calc_en_o,
                open && inp_valid_i && weight_valid_i && bias_valid_i);
    pend = calc_en_o;
    if (oup_valid_i && oup_ready_i) occ_model--;
    if (calc_en_o) begin
      step_geometry(step_o, inner_n, x_n, cols);
      check_value("inner_tile_o", inner_tile_o, trk_inner);
      check_value("tile_x_o", tile_x_o, trk_x);
      check_value("tile_y_o", tile_y_o, trk_y);
      check_value("first_inner_tile_o", first_inner_tile_o, trk_inner == 0);
      check_value("last_inner_tile_o", last_inner_tile_o, trk_inner == inner_n - 1);
      m = ref_mask(trk_beat, trk_x, trk_y, seq_length_i, cols);
      for (int i = 0; i < Lanes; i++) begin
        exp_bias[i] = m[i] ? bias_i[i] : '0;
      end
      exp_rq = m & {Lanes{requant_add_i}};
      if (trk_y * TileRows + trk_beat % TileRows >= seq_length_i) zero_rows++;
      else if (m != '1 && m != '0) partial_beats++;
      beat_count[int'(step_o)]++;
      if (trk_inner == inner_n - 1) begin
        pushes++;
        occ_model++;
      end
      trk_beat++;
      if (trk_beat == BeatsPerTile) begin
        trk_beat = 0;
        trk_inner++;
        if (trk_inner == inner_n) begin
          trk_inner = 0;
          trk_x++;
          if (trk_x == x_n) begin
            trk_x = 0;
            trk_y++;
            if (trk_y == ceil_tiles(seq_length_i)) trk_y = 0;  // step done
          end
        end
      end
    end
  endtask

  always begin
    @(negedge clk_i);
    #(ClkPeriod / 4);
    if (rst_ni) sample_cycle();
  end

  task automatic drive_inputs(input bit gaps);
    inp_valid_i    = gaps ? ($urandom % 4 != 0) : 1'b1;
    weight_valid_i = gaps ? ($urandom % 4 != 0) : 1'b1;
    bias_valid_i   = gaps ? ($urandom % 4 != 0) : 1'b1;
    for (int i = 0; i < Lanes; i++) begin
      bias_i[i] = bias_lane_t'($urandom);
    end
    requant_add_i = $urandom % 2;
    oup_valid_i   = occ_model > 0;  // never pop an empty fifo
    oup_ready_i   = gaps ? ($urandom % 2) : drain_en;
  endtask

  task automatic start_layer(input layer_e layer, input int seq, input int embed,
                             input int proj, input int ff);
    @(negedge clk_i);
    seq_length_i = dim_t'(seq);
    embed_size_i = dim_t'(embed);
    proj_space_i = dim_t'(proj);
    ff_size_i    = dim_t'(ff);
    layer_i      = layer;
    start_i      = 1'b1;
    beat_count   = '{default: 0};
    step_seen.delete();
    pushes        = 0;
    zero_rows     = 0;
    partial_beats = 0;
    drive_inputs(1'b0);
  endtask

  // runs until the layer is done and the output fifo is empty
  task automatic finish_layer(input bit gaps, input string what);
    int cycles;
    bit seen_busy;
    cycles    = 0;
    seen_busy = 1'b0;
    forever begin
      @(negedge clk_i);
      start_i = 1'b0;
      drive_inputs(gaps);
      if (step_o != Idle) begin
        seen_busy = 1'b1;
        check_value("busy_o", busy_o, 1'b1);
      end
      if (seen_busy && step_o == Idle && occ_model == 0) break;
      cycles++;
      if (cycles > LongWait) abort_run({what, " did not finish"});
    end
  endtask

  task automatic expect_trace(input int n, input step_e a, input step_e b, input step_e c);
    step_e want [3];
    want = '{a, b, c};
    if (step_seen.size() != n) begin
      errors++;
      $display("step_o went through %0d steps, expected %0d", step_seen.size(), n);
    end else begin
      for (int k = 0; k < n; k++) begin
        check_value("step_o", step_seen[k], want[k]);
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, total_errors() - errs_before);
    end
  endtask

  initial begin
    int errs, cycles;
    void'($urandom(Seed));
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    layer_i        = Linear;
    seq_length_i   = 8'd1;
    embed_size_i   = 8'd1;
    proj_space_i   = 8'd1;
    ff_size_i      = 8'd1;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
    oup_valid_i    = 1'b0;
    oup_ready_i    = 1'b0;
    bias_i         = '0;
    requant_add_i  = 1'b0;
    {errors, tests_run, tests_failed, occ_model} = '0;
    {trk_beat, trk_inner, trk_x, trk_y} = '0;
    pend      = 1'b0;
    drain_en  = 1'b1;
    last_step = Idle;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    errs = total_errors();
    @(negedge clk_i);
    drive_inputs(1'b0);  // valids high, idle must still refuse
    #(ClkPeriod / 4);
    check_value("step_o", step_o, Idle);
    check_value("busy_o", busy_o, 1'b0);
    check_value("ready", {inp_ready_o, weight_ready_o, bias_ready_o}, 3'b000);
    check_value("calc_en_o", calc_en_o, 1'b0);
    check_value("pad_valid_o", pad_valid_o, 1'b0);
    report_test("reset state", errs);

    errs = total_errors();
    start_layer(Linear, 11, 13, 10, 20);
    finish_layer(1'b0, "linear layer");
    check_value("matmul beats", beat_count[MatMul], expected_beats(MatMul));
    expect_trace(2, MatMul, Idle, Idle);
    check_value("busy_o", busy_o, 1'b0);
    report_test("linear layer", errs);

    errs = total_errors();
    start_layer(Feedforward, 11, 13, 10, 20);
    finish_layer(1'b0, "feedforward layer");
    check_value("f1 beats", beat_count[F1], expected_beats(F1));
    check_value("f2 beats", beat_count[F2], expected_beats(F2));
    expect_trace(3, F1, F2, Idle);
    report_test("feedforward layer", errs);

    errs = total_errors();
    start_layer(Linear, 5, 9, 6, 20);  // rows past 5, lanes past column 6
    finish_layer(1'b0, "padding layer");
    check_value("matmul beats", beat_count[MatMul], expected_beats(MatMul));
    if (zero_rows == 0 || partial_beats == 0) begin
      errors++;
      $display("padding run saw no zeroed row or no partial beat");
    end
    report_test("edge padding", errs);

    errs = total_errors();
    drain_en = 1'b0;
    start_layer(Linear, 11, 13, 10, 20);
    cycles = 0;
    while (pushes < FifoDepth) begin
      @(negedge clk_i);
      start_i = 1'b0;
      drive_inputs(1'b0);
      cycles++;
      if (cycles > FillWait) abort_run("output fifo never filled");
    end
    repeat (StallLen) begin
      @(negedge clk_i);
      drive_inputs(1'b0);
      #(ClkPeriod / 4);
      check_value("ready", {inp_ready_o, weight_ready_o, bias_ready_o}, 3'b000);
      check_value("calc_en_o", calc_en_o, 1'b0);
    end
    check_value("last inner beats", pushes, FifoDepth);
    drain_en = 1'b1;
    finish_layer(1'b0, "stalled linear layer");
    check_value("matmul beats", beat_count[MatMul], expected_beats(MatMul));
    report_test("back-pressure", errs);

    errs = total_errors();
    start_layer(Feedforward, 11, 13, 10, 20);
    finish_layer(1'b1, "feedforward layer with gaps");
    check_value("f1 beats", beat_count[F1], expected_beats(F1));
    check_value("f2 beats", beat_count[F2], expected_beats(F2));
    expect_trace(3, F1, F2, Idle);
    report_test("random valid gaps", errs);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
